// ==== Makefile ====
VERILATOR = verilator
FLAGS = --timing --timescale 1ns/1ps
TOP = tb_vai
FILELIST = verilog.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_vai.sv ====
`default_nettype none
`include "vai_cfg.svh"

module tb_vai;
    timeunit 1ns;
    timeprecision 100ps;

    import vai_pkg::*;

    typedef struct
    {
        string name;
        int group;  // Entries of one group are issued together
        int hold;  // Almost-full cycles at the start of the group
        logic [`VAI_VMID_W-1:0] afu;
        bit is_wr;
        t_req_type kind;
        t_offset addr;
        logic [`VAI_MDATA_W-1:0] mdata;
        logic [`VAI_CL_LEN_W-1:0] cl_len;
        logic sop;
        logic [`VAI_DATA_W-1:0] data;
    } t_stim;

    logic clk;
    logic reset;
    logic cfg_wr;
    logic [`VAI_VMID_W-1:0] cfg_idx;
    t_offset cfg_offset;
    logic [`VAI_NUM_AFUS-1:0] afu_rd_valid;
    t_rd_hdr afu_rd_hdr [`VAI_NUM_AFUS];
    logic [`VAI_NUM_AFUS-1:0] afu_rd_ready;
    logic [`VAI_NUM_AFUS-1:0] afu_wr_valid;
    t_wr_hdr afu_wr_hdr [`VAI_NUM_AFUS];
    logic [`VAI_DATA_W-1:0] afu_wr_data [`VAI_NUM_AFUS];
    logic [`VAI_NUM_AFUS-1:0] afu_wr_ready;
    logic up_almfull;
    logic up_rd_valid;
    t_rd_hdr up_rd_hdr;
    logic up_wr_valid;
    t_wr_hdr up_wr_hdr;
    logic [`VAI_DATA_W-1:0] up_wr_data;

    t_stim stim [$];
    t_offset offset_cfg [`VAI_NUM_AFUS];
    int rd_pend [`VAI_NUM_AFUS][$];  // Table indices not yet accepted
    int wr_pend [`VAI_NUM_AFUS][$];
    int rd_sb [`VAI_NUM_AFUS][$];  // Accepted, waiting for the host port
    int wr_sb [`VAI_NUM_AFUS][$];
    int seed;
    int last_group;
    int final_errors;
    int value_errors = 0;
    int flow_errors = 0;
    logic almfull_seen = 1'b0;
    logic ready_dropped = 1'b0;

    vai_top i_vai_top (.clk(clk), .reset(reset), .cfg_wr(cfg_wr), .cfg_idx(cfg_idx),
        .cfg_offset(cfg_offset), .afu_rd_valid(afu_rd_valid), .afu_rd_hdr(afu_rd_hdr),
        .afu_rd_ready(afu_rd_ready), .afu_wr_valid(afu_wr_valid), .afu_wr_hdr(afu_wr_hdr),
        .afu_wr_data(afu_wr_data), .afu_wr_ready(afu_wr_ready), .up_almfull(up_almfull),
        .up_rd_valid(up_rd_valid), .up_rd_hdr(up_rd_hdr), .up_wr_valid(up_wr_valid),
        .up_wr_hdr(up_wr_hdr), .up_wr_data(up_wr_data));

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [63:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    task automatic add_entry(input string name, input int group, input int hold, input int afu,
        input bit is_wr, input t_req_type kind);
        t_stim s;
        logic [63:0] w;
        s.name = name;
        s.group = group;
        s.hold = hold;
        s.afu = (`VAI_VMID_W)'(afu);
        s.is_wr = is_wr;
        s.kind = kind;
        w = random_word();
        s.addr = w[`VAI_ADDR_W-1:0];
        w = random_word();
        s.mdata = w[`VAI_MDATA_W-1:0];  // Random upper bits for the VMID stamp to overwrite
        s.cl_len = w[`VAI_MDATA_W+`VAI_CL_LEN_W-1:`VAI_MDATA_W];
        s.sop = w[`VAI_MDATA_W+`VAI_CL_LEN_W];
        s.data = random_word();
        stim.push_back(s);
    endtask

    task automatic fill_table();
        for (int n = 0; n < `VAI_NUM_AFUS; n++)
        begin
            add_entry($sformatf("offset_rd_%0d", n), n, 0, n, 1'b0, rd_line);
            add_entry($sformatf("offset_wr_%0d", n), n, 0, n, 1'b1, wr_line);
        end
        add_entry("fence_2", 8, 0, 2, 1'b1, wr_fence);
        add_entry("fence_5", 8, 0, 5, 1'b1, wr_fence);
        for (int k = 0; k < 2; k++)
        begin
            for (int n = 0; n < `VAI_NUM_AFUS; n++)
            begin
                add_entry($sformatf("merge_rd_%0d_%0d", n, k), 9, 0, n, 1'b0, rd_line);
                add_entry($sformatf("merge_wr_%0d_%0d", n, k), 9, 0, n, 1'b1, wr_line);
            end
        end
        for (int k = 0; k < 3; k++)
        begin
            for (int n = 0; n < `VAI_NUM_AFUS; n++)
            begin
                add_entry($sformatf("almfull_rd_%0d_%0d", n, k), 10, 40, n, 1'b0, rd_line);
                add_entry($sformatf("almfull_wr_%0d_%0d", n, k), 10, 40, n, 1'b1,
                    (k == 1 && n == 4) ? wr_fence : wr_line);
            end
        end
        last_group = 10;
    endtask

    // ####################
    // Expected upstream headers
    // ####################
    function automatic t_rd_hdr expect_rd(input int i);
        t_rd_hdr h;
        h.address = stim[i].addr + offset_cfg[stim[i].afu];
        h.cl_len = stim[i].cl_len;
        h.mdata.raw = stim[i].mdata;
        h.mdata.split.vmid = stim[i].afu;  // Local tag bits stay as issued
        return h;
    endfunction

    function automatic t_wr_hdr expect_wr(input int i);
        t_wr_hdr h;
        h.req_type = stim[i].kind;
        h.sop = stim[i].sop;
        h.address = (stim[i].kind == wr_fence) ? '0 : stim[i].addr + offset_cfg[stim[i].afu];
        h.cl_len = stim[i].cl_len;
        h.mdata.raw = stim[i].mdata;
        h.mdata.split.vmid = stim[i].afu;
        return h;
    endfunction

    task automatic check_rd(input string name, input t_rd_hdr exp_hdr, input t_rd_hdr act_hdr);
        if (act_hdr !== exp_hdr)
        begin
            value_errors++;
            $display("error %s: expected %h, actual %h", name, exp_hdr, act_hdr);
        end
    endtask

    task automatic check_wr(input string name, input t_wr_hdr exp_hdr,
        input logic [`VAI_DATA_W-1:0] exp_data, input t_wr_hdr act_hdr,
        input logic [`VAI_DATA_W-1:0] act_data);
        if (act_hdr !== exp_hdr || act_data !== exp_data)
        begin
            value_errors++;
            $display("error %s: expected %h data %h, actual %h data %h", name, exp_hdr,
                exp_data, act_hdr, act_data);
        end
    endtask

    task automatic configure_offsets();
        logic [63:0] w;
        for (int n = 0; n < `VAI_NUM_AFUS; n++)
        begin
            w = random_word();
            offset_cfg[(`VAI_VMID_W)'(n)] = w[`VAI_ADDR_W-1:0];
            cfg_wr <= 1'b1;
            cfg_idx <= (`VAI_VMID_W)'(n);
            cfg_offset <= w[`VAI_ADDR_W-1:0];
            @(posedge clk);
        end
        cfg_wr <= 1'b0;
    endtask

    // Runs right after a rising edge and sees the values from before it
    task automatic drive_ports();
        logic [`VAI_VMID_W-1:0] p;
        int i;
        for (int n = 0; n < `VAI_NUM_AFUS; n++)
        begin
            p = (`VAI_VMID_W)'(n);
            if (afu_rd_valid[p] && afu_rd_ready[p])
            begin
                rd_sb[p].push_back(rd_pend[p].pop_front());
            end
            if (afu_wr_valid[p] && afu_wr_ready[p])
            begin
                wr_sb[p].push_back(wr_pend[p].pop_front());
            end
            afu_rd_valid[p] <= (rd_pend[p].size() > 0);
            if (rd_pend[p].size() > 0)
            begin
                i = rd_pend[p][0];
                afu_rd_hdr[p] <= '{address: stim[i].addr, cl_len: stim[i].cl_len,
                    mdata: stim[i].mdata};
            end
            afu_wr_valid[p] <= (wr_pend[p].size() > 0);
            if (wr_pend[p].size() > 0)
            begin
                i = wr_pend[p][0];
                afu_wr_hdr[p] <= '{req_type: stim[i].kind, sop: stim[i].sop,
                    address: stim[i].addr, cl_len: stim[i].cl_len, mdata: stim[i].mdata};
                afu_wr_data[p] <= stim[i].data;
            end
        end
    endtask

    function automatic bit busy();
        logic [`VAI_VMID_W-1:0] p;
        bit b;
        b = 1'b0;
        for (int n = 0; n < `VAI_NUM_AFUS; n++)
        begin
            p = (`VAI_VMID_W)'(n);
            if (rd_pend[p].size() + wr_pend[p].size() + rd_sb[p].size() + wr_sb[p].size() > 0)
            begin
                b = 1'b1;
            end
        end
        return b;
    endfunction

    task automatic run_group(input int g);
        int hold;
        int cycles;
        hold = 0;
        cycles = 0;
        foreach (stim[i])
        begin
            if (stim[i].group == g)
            begin
                if (stim[i].is_wr)
                begin
                    wr_pend[stim[i].afu].push_back(i);
                end
                else
                begin
                    rd_pend[stim[i].afu].push_back(i);
                end
                if (stim[i].hold > hold)
                begin
                    hold = stim[i].hold;
                end
            end
        end
        up_almfull <= (hold > 0);
        while (busy())
        begin
            @(posedge clk);
            cycles++;
            if (cycles == hold)
            begin
                up_almfull <= 1'b0;
            end
            drive_ports();
        end
    endtask

    // ####################
    // Upstream monitor
    // ####################
    always @(posedge clk)
    begin
        int i;
        if (!reset)
        begin
            if ((up_rd_valid || up_wr_valid) && almfull_seen)
            begin
                flow_errors++;
                $display("Upstream request issued while almost full was high");
            end
            if (up_almfull && (afu_rd_ready & afu_wr_ready) != '1)
            begin
                ready_dropped <= 1'b1;
            end
            if (up_rd_valid && rd_sb[up_rd_hdr.mdata.split.vmid].size() == 0)
            begin
                flow_errors++;
                $display("Unexpected read upstream for sub-AFU %0d", up_rd_hdr.mdata.split.vmid);
            end
            else if (up_rd_valid)
            begin
                i = rd_sb[up_rd_hdr.mdata.split.vmid].pop_front();
                check_rd(stim[i].name, expect_rd(i), up_rd_hdr);
            end
            if (up_wr_valid && wr_sb[up_wr_hdr.mdata.split.vmid].size() == 0)
            begin
                flow_errors++;
                $display("Unexpected write upstream for sub-AFU %0d", up_wr_hdr.mdata.split.vmid);
            end
            else if (up_wr_valid)
            begin
                i = wr_sb[up_wr_hdr.mdata.split.vmid].pop_front();
                check_wr(stim[i].name, expect_wr(i), stim[i].data, up_wr_hdr, up_wr_data);
            end
        end
        almfull_seen <= up_almfull;  // Grants follow almost full with one cycle of delay
    end

    initial
    begin
        @(negedge reset);
        repeat ((stim.size() + 50) * 20) @(posedge clk);
        $display("Timeout: requests still outstanding, %0d value and %0d flow errors so far",
            value_errors, flow_errors);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        seed = 67660;
        final_errors = 0;
        reset <= 1'b1;
        cfg_wr <= 1'b0;
        cfg_idx <= '0;
        cfg_offset <= '0;
        afu_rd_valid <= '0;
        afu_wr_valid <= '0;
        up_almfull <= 1'b0;
        for (int n = 0; n < `VAI_NUM_AFUS; n++)
        begin
            afu_rd_hdr[(`VAI_VMID_W)'(n)] <= '0;
            afu_wr_hdr[(`VAI_VMID_W)'(n)] <= '0;
            afu_wr_data[(`VAI_VMID_W)'(n)] <= '0;
        end
        fill_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        configure_offsets();
        for (int g = 0; g <= last_group; g++)
        begin
            run_group(g);
        end
        repeat (10) @(posedge clk);  // Anything arriving now is a duplicate
        if (!ready_dropped)
        begin
            final_errors++;
            $display("Ready never dropped while almost full was held");
        end
        $display("Errors: %0d value, %0d flow, %0d final", value_errors, flow_errors,
            final_errors);
        if (value_errors + flow_errors + final_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vai_cfg.svh ====
`ifndef VAI_CFG_SVH
`define VAI_CFG_SVH

// Number of sub-AFUs sharing the host port, kept a power of two
`define VAI_NUM_AFUS 8

// VMID width, log2 of the sub-AFU count
`define VAI_VMID_W 3

`define VAI_ADDR_W 42  // Cache-line address width
`define VAI_DATA_W 64  // Write data carried per request
`define VAI_MDATA_W 16  // Request tag width
`define VAI_CL_LEN_W 2  // Line count encoding

`endif

// ==== vai_if.sv ====
`default_nettype none
`include "vai_cfg.svh"

// Translated read request from one sub-AFU
interface vai_rd_if;
    import vai_pkg::*;

    logic valid;
    t_rd_hdr hdr;
    logic grant;  // Request leaves stage 2 when valid and grant are both high

    modport xlate (output valid, output hdr, input grant);
    modport arb (input valid, input hdr, output grant);

endinterface

// Translated write request from one sub-AFU
interface vai_wr_if;
    import vai_pkg::*;

    logic valid;
    t_wr_hdr hdr;
    logic [`VAI_DATA_W-1:0] data;
    logic grant;

    modport xlate (output valid, output hdr, output data, input grant);
    modport arb (input valid, input hdr, input data, output grant);

endinterface

`default_nettype wire

// ==== vai_offset_regs.sv ====
`default_nettype none
`include "vai_cfg.svh"

module vai_offset_regs
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    cfg_wr,
    input  wire [`VAI_VMID_W-1:0]  cfg_idx,
    input  wire vai_pkg::t_offset  cfg_offset,
    output vai_pkg::t_offset       offsets [`VAI_NUM_AFUS]
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `VAI_NUM_AFUS; i++)
            begin
                offsets[i] <= '0;  // Every sub-AFU starts at host address zero
            end
        end
        else if (cfg_wr)
        begin
            offsets[cfg_idx] <= cfg_offset;
        end
    end

endmodule

`default_nettype wire

// ==== vai_pkg.sv ====
`default_nettype none
`include "vai_cfg.svh"

package vai_pkg;

    typedef enum logic [1:0]
    {
        rd_line,
        wr_line,
        wr_fence
    } t_req_type;

    typedef struct packed
    {
        logic [`VAI_VMID_W-1:0] vmid;  // Owning sub-AFU
        logic [`VAI_MDATA_W-`VAI_VMID_W-1:0] tag;  // Sub-AFU local tag
    } t_mdata_split;

    // The sub-AFU sees raw, the host port sees the split view
    typedef union packed
    {
        logic [`VAI_MDATA_W-1:0] raw;
        t_mdata_split split;
    } t_mdata;

    typedef logic [`VAI_ADDR_W-1:0] t_offset;

    typedef struct packed
    {
        logic [`VAI_ADDR_W-1:0] address;
        logic [`VAI_CL_LEN_W-1:0] cl_len;
        t_mdata mdata;
    } t_rd_hdr;

    typedef struct packed
    {
        t_req_type req_type;
        logic sop;  // Start of a multi-line write
        logic [`VAI_ADDR_W-1:0] address;
        logic [`VAI_CL_LEN_W-1:0] cl_len;
        t_mdata mdata;
    } t_wr_hdr;

endpackage

`default_nettype wire

// ==== vai_rd_xlate.sv ====
`default_nettype none
`include "vai_cfg.svh"

module vai_rd_xlate
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire [`VAI_NUM_AFUS-1:0]    afu_valid,
    input  wire vai_pkg::t_rd_hdr      afu_hdr [`VAI_NUM_AFUS],
    output logic [`VAI_NUM_AFUS-1:0]   afu_ready,
    input  wire vai_pkg::t_offset      offsets [`VAI_NUM_AFUS],
    vai_rd_if.xlate                    rd [`VAI_NUM_AFUS]
);
    import vai_pkg::*;

    for (genvar n = 0; n < `VAI_NUM_AFUS; n++)
    begin : g_afu
        localparam logic [`VAI_VMID_W-1:0] afu_vmid = (`VAI_VMID_W)'(n);

        logic s1_valid;
        t_rd_hdr s1_hdr;
        t_offset s1_offset;
        logic s2_valid;
        t_rd_hdr s2_hdr;
        logic s2_ready;

        assign s2_ready = !s2_valid || rd[n].grant;  // Stage 2 empties on grant
        assign afu_ready[n] = !s1_valid || s2_ready;

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                s1_valid <= 1'b0;
                s2_valid <= 1'b0;
            end
            else
            begin
                if (afu_ready[n])
                begin
                    s1_valid <= afu_valid[n];
                end
                if (s2_ready)
                begin
                    s2_valid <= s1_valid;
                end
            end
        end

        // ####################
        // Capture, then add the offset and stamp the VMID
        // ####################
        always_ff @(posedge clk)
        begin
            if (afu_valid[n] && afu_ready[n])
            begin
                s1_hdr <= afu_hdr[n];
                s1_offset <= offsets[n];  // Offset as of the accepting edge
            end
            if (s1_valid && s2_ready)
            begin
                s2_hdr.address <= s1_hdr.address + s1_offset;
                s2_hdr.cl_len <= s1_hdr.cl_len;
                s2_hdr.mdata.split.vmid <= afu_vmid;
                s2_hdr.mdata.split.tag <= s1_hdr.mdata.split.tag;
            end
        end

        assign rd[n].valid = s2_valid;
        assign rd[n].hdr = s2_hdr;
    end

endmodule

`default_nettype wire

// ==== vai_top.sv ====
`default_nettype none
`include "vai_cfg.svh"

module vai_top
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        cfg_wr,
    input  wire [`VAI_VMID_W-1:0]      cfg_idx,
    input  wire vai_pkg::t_offset      cfg_offset,
    input  wire [`VAI_NUM_AFUS-1:0]    afu_rd_valid,
    input  wire vai_pkg::t_rd_hdr      afu_rd_hdr [`VAI_NUM_AFUS],
    output logic [`VAI_NUM_AFUS-1:0]   afu_rd_ready,
    input  wire [`VAI_NUM_AFUS-1:0]    afu_wr_valid,
    input  wire vai_pkg::t_wr_hdr      afu_wr_hdr [`VAI_NUM_AFUS],
    input  wire [`VAI_DATA_W-1:0]      afu_wr_data [`VAI_NUM_AFUS],
    output logic [`VAI_NUM_AFUS-1:0]   afu_wr_ready,
    input  wire                        up_almfull,
    output logic                       up_rd_valid,
    output vai_pkg::t_rd_hdr           up_rd_hdr,
    output logic                       up_wr_valid,
    output vai_pkg::t_wr_hdr           up_wr_hdr,
    output logic [`VAI_DATA_W-1:0]     up_wr_data
);
    import vai_pkg::*;

    t_offset offsets [`VAI_NUM_AFUS];

    vai_rd_if rd_if [`VAI_NUM_AFUS] ();  // One read and one write link per sub-AFU
    vai_wr_if wr_if [`VAI_NUM_AFUS] ();

    vai_offset_regs i_vai_offset_regs (.clk(clk), .reset(reset), .cfg_wr(cfg_wr),
        .cfg_idx(cfg_idx), .cfg_offset(cfg_offset), .offsets(offsets));

    vai_rd_xlate i_vai_rd_xlate (.clk(clk), .reset(reset), .afu_valid(afu_rd_valid),
        .afu_hdr(afu_rd_hdr), .afu_ready(afu_rd_ready), .offsets(offsets),
        .rd(rd_if));

    vai_wr_xlate i_vai_wr_xlate (.clk(clk), .reset(reset), .afu_valid(afu_wr_valid),
        .afu_hdr(afu_wr_hdr), .afu_data(afu_wr_data), .afu_ready(afu_wr_ready),
        .offsets(offsets), .wr(wr_if));

    vai_up_arb i_vai_up_arb (.clk(clk), .reset(reset), .up_almfull(up_almfull),
        .rd(rd_if), .wr(wr_if), .up_rd_valid(up_rd_valid), .up_rd_hdr(up_rd_hdr),
        .up_wr_valid(up_wr_valid), .up_wr_hdr(up_wr_hdr), .up_wr_data(up_wr_data));

endmodule

`default_nettype wire

// ==== vai_up_arb.sv ====
`default_nettype none
`include "vai_cfg.svh"

module vai_up_arb
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      up_almfull,
    vai_rd_if.arb                    rd [`VAI_NUM_AFUS],
    vai_wr_if.arb                    wr [`VAI_NUM_AFUS],
    output logic                     up_rd_valid,
    output vai_pkg::t_rd_hdr         up_rd_hdr,
    output logic                     up_wr_valid,
    output vai_pkg::t_wr_hdr         up_wr_hdr,
    output logic [`VAI_DATA_W-1:0]   up_wr_data
);
    import vai_pkg::*;

    logic [`VAI_NUM_AFUS-1:0] rd_req;
    logic [`VAI_NUM_AFUS-1:0] wr_req;
    logic [`VAI_NUM_AFUS-1:0] rd_gnt;
    logic [`VAI_NUM_AFUS-1:0] wr_gnt;
    t_rd_hdr rd_hdr_a [`VAI_NUM_AFUS];
    t_wr_hdr wr_hdr_a [`VAI_NUM_AFUS];
    logic [`VAI_DATA_W-1:0] wr_data_a [`VAI_NUM_AFUS];
    logic [`VAI_VMID_W-1:0] rd_ptr;
    logic [`VAI_VMID_W-1:0] wr_ptr;
    logic [`VAI_VMID_W-1:0] rd_pick;
    logic [`VAI_VMID_W-1:0] wr_pick;
    logic rd_go;
    logic wr_go;

    // First requester at or after ptr, wrapping around
    function automatic logic [`VAI_VMID_W-1:0] rr_pick(
        input logic [`VAI_NUM_AFUS-1:0] req,
        input logic [`VAI_VMID_W-1:0] ptr
    );
        logic [`VAI_VMID_W-1:0] idx;
        logic [`VAI_VMID_W-1:0] pick;
        logic found;
        pick = ptr;
        found = 1'b0;
        for (int i = 0; i < `VAI_NUM_AFUS; i++)
        begin
            idx = ptr + i[`VAI_VMID_W-1:0];
            if (!found && req[idx])
            begin
                found = 1'b1;
                pick = idx;
            end
        end
        return pick;
    endfunction

    for (genvar n = 0; n < `VAI_NUM_AFUS; n++)
    begin : g_port
        assign rd_req[n] = rd[n].valid;
        assign rd_hdr_a[n] = rd[n].hdr;
        assign rd[n].grant = rd_gnt[n];
        assign wr_req[n] = wr[n].valid;
        assign wr_hdr_a[n] = wr[n].hdr;
        assign wr_data_a[n] = wr[n].data;
        assign wr[n].grant = wr_gnt[n];
    end

    // ####################
    // Grant selection
    // ####################
    assign rd_pick = rr_pick(rd_req, rd_ptr);
    assign wr_pick = rr_pick(wr_req, wr_ptr);
    assign rd_go = |rd_req && !up_almfull;  // Host back-pressure blocks every grant
    assign wr_go = |wr_req && !up_almfull;

    always_comb
    begin
        rd_gnt = '0;
        wr_gnt = '0;
        if (rd_go)
        begin
            rd_gnt[rd_pick] = 1'b1;
        end
        if (wr_go)
        begin
            wr_gnt[wr_pick] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            up_rd_valid <= 1'b0;
            up_wr_valid <= 1'b0;
            rd_ptr <= '0;
            wr_ptr <= '0;
        end
        else
        begin
            up_rd_valid <= rd_go;
            up_wr_valid <= wr_go;
            if (rd_go)
            begin
                rd_ptr <= rd_pick + 1'b1;  // Winner drops to lowest priority
            end
            if (wr_go)
            begin
                wr_ptr <= wr_pick + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_go)
        begin
            up_rd_hdr <= rd_hdr_a[rd_pick];
        end
        if (wr_go)
        begin
            up_wr_hdr <= wr_hdr_a[wr_pick];
            up_wr_data <= wr_data_a[wr_pick];
        end
    end

endmodule

`default_nettype wire

// ==== vai_wr_xlate.sv ====
`default_nettype none
`include "vai_cfg.svh"

module vai_wr_xlate
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire [`VAI_NUM_AFUS-1:0]    afu_valid,
    input  wire vai_pkg::t_wr_hdr      afu_hdr [`VAI_NUM_AFUS],
    input  wire [`VAI_DATA_W-1:0]      afu_data [`VAI_NUM_AFUS],
    output logic [`VAI_NUM_AFUS-1:0]   afu_ready,
    input  wire vai_pkg::t_offset      offsets [`VAI_NUM_AFUS],
    vai_wr_if.xlate                    wr [`VAI_NUM_AFUS]
);
    import vai_pkg::*;

    for (genvar n = 0; n < `VAI_NUM_AFUS; n++)
    begin : g_afu
        localparam logic [`VAI_VMID_W-1:0] afu_vmid = (`VAI_VMID_W)'(n);

        logic s1_valid;
        t_wr_hdr s1_hdr;
        logic [`VAI_DATA_W-1:0] s1_data;
        t_offset s1_offset;
        logic s2_valid;
        t_wr_hdr s2_hdr;
        logic [`VAI_DATA_W-1:0] s2_data;
        logic s2_ready;

        assign s2_ready = !s2_valid || wr[n].grant;
        assign afu_ready[n] = !s1_valid || s2_ready;  // Stage 1 empty or moving on

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                s1_valid <= 1'b0;
                s2_valid <= 1'b0;
            end
            else
            begin
                if (afu_ready[n])
                begin
                    s1_valid <= afu_valid[n];
                end
                if (s2_ready)
                begin
                    s2_valid <= s1_valid;
                end
            end
        end

        // ####################
        // Capture, then translate
        // ####################
        always_ff @(posedge clk)
        begin
            if (afu_valid[n] && afu_ready[n])
            begin
                s1_hdr <= afu_hdr[n];
                s1_data <= afu_data[n];
                s1_offset <= offsets[n];
            end
            if (s1_valid && s2_ready)
            begin
                // A fence carries no address of its own
                s2_hdr.address <= (s1_hdr.req_type == wr_fence) ? '0 :
                                  s1_hdr.address + s1_offset;
                s2_hdr.req_type <= s1_hdr.req_type;
                s2_hdr.sop <= s1_hdr.sop;
                s2_hdr.cl_len <= s1_hdr.cl_len;
                s2_hdr.mdata.split.vmid <= afu_vmid;
                s2_hdr.mdata.split.tag <= s1_hdr.mdata.split.tag;
                s2_data <= s1_data;
            end
        end

        assign wr[n].valid = s2_valid;
        assign wr[n].hdr = s2_hdr;
        assign wr[n].data = s2_data;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
vai_pkg.sv
vai_if.sv
vai_offset_regs.sv
vai_rd_xlate.sv
vai_wr_xlate.sv
vai_up_arb.sv
vai_top.sv
tb_vai.sv
